/* logic/cpuPkg.sv */
package cpuPkg;

    // ----------------------------------------------------------------------
    // Sizes
    // ----------------------------------------------------------------------
    localparam int DataWidth    = 16;
    localparam int RegCount     = 16;
    localparam int RegAddrWidth = 4;
    localparam int InstrWidth   = 19;

    typedef logic signed [DataWidth-1:0]   dataT;
    // Full multiplier width, also used for every execute result
    typedef logic signed [2*DataWidth-1:0] wideT;
    typedef logic [RegAddrWidth-1:0]       regAddrT;

    // ----------------------------------------------------------------------
    // Encodings
    // ----------------------------------------------------------------------
    typedef enum logic [2:0] {
        OpRType = 3'b000,
        OpMult  = 3'b001,
        OpBeq   = 3'b010,
        OpAddi  = 3'b011,
        OpSubi  = 3'b100,
        OpStore = 3'b101,
        OpLoad  = 3'b110,
        OpSlt   = 3'b111
    } opcodeT;

    // Function code sits in the rl field of the register format
    typedef enum logic [3:0] {
        FnAnd = 4'd0,
        FnOr  = 4'd1,
        FnXor = 4'd2,
        FnAdd = 4'd3,
        FnSub = 4'd4
    } funcT;

    typedef struct packed {
        opcodeT  opcode;
        regAddrT rs;
        regAddrT rt;
        regAddrT rd;
        regAddrT rl;
    } rFormatT;

    typedef struct packed {
        opcodeT            opcode;
        regAddrT           rs;
        regAddrT           rt;
        logic signed [7:0] imm;
    } iFormatT;

    typedef union packed {
        rFormatT r;
        iFormatT i;
    } instrT;

    // ----------------------------------------------------------------------
    // Pipeline items
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic    valid;
        opcodeT  opcode;
        funcT    func;
        dataT    rsValue;
        dataT    rtValue;
        dataT    imm;
        regAddrT rd;
        regAddrT rl;
        regAddrT rt;
    } decodedT;

    typedef struct packed {
        logic    valid;
        opcodeT  opcode;
        regAddrT rd;
        regAddrT rl;
        regAddrT rt;
        wideT    result;
    } resultT;

    typedef dataT [RegCount-1:0] regViewT;

endpackage

/* logic/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            inValid,
    input  cpuPkg::instrT   instruction,
    input  cpuPkg::resultT  exItem,
    input  cpuPkg::dataT    rsValue,
    input  cpuPkg::dataT    rtValue,
    output logic            busy,
    output cpuPkg::regAddrT rsIndex,
    output cpuPkg::regAddrT rtIndex,
    output cpuPkg::decodedT decoded
);

    cpuPkg::rFormatT rForm;
    cpuPkg::iFormatT iForm;
    cpuPkg::decodedT decReg;
    cpuPkg::decodedT nextDec;
    logic            decHit;
    logic            exHit;
    logic            accept;

    // True when an item with this opcode will write register idx
    function automatic logic writesReg(
        input cpuPkg::opcodeT  op,
        input cpuPkg::regAddrT rd,
        input cpuPkg::regAddrT rl,
        input cpuPkg::regAddrT rt,
        input cpuPkg::regAddrT idx
    );
        logic hit;
        case (op)
            cpuPkg::OpRType: hit = (rd == idx);
            cpuPkg::OpMult, cpuPkg::OpBeq, cpuPkg::OpSlt: begin
                hit = (rd == idx) || (rl == idx);
            end
            cpuPkg::OpAddi, cpuPkg::OpSubi: hit = (rt == idx);
            default: hit = 1'b0;
        endcase
        return hit;
    endfunction

    assign rForm = instruction.r;
    assign iForm = instruction.i;

    assign rsIndex = rForm.rs;
    assign rtIndex = rForm.rt;

    // ----------------------------------------------------------------------
    // Read-after-write interlock
    // ----------------------------------------------------------------------
    assign decHit = decReg.valid &&
        (writesReg(decReg.opcode, decReg.rd, decReg.rl, decReg.rt, rForm.rs) ||
         writesReg(decReg.opcode, decReg.rd, decReg.rl, decReg.rt, rForm.rt));

    assign exHit = exItem.valid &&
        (writesReg(exItem.opcode, exItem.rd, exItem.rl, exItem.rt, rForm.rs) ||
         writesReg(exItem.opcode, exItem.rd, exItem.rl, exItem.rt, rForm.rt));

    assign busy   = inValid && (decHit || exHit);
    assign accept = inValid && !busy;

    // ----------------------------------------------------------------------
    // Decode register
    // ----------------------------------------------------------------------
    always_comb begin
        nextDec.valid   = accept;
        nextDec.opcode  = rForm.opcode;
        nextDec.func    = cpuPkg::funcT'(rForm.rl);
        nextDec.rsValue = rsValue;
        nextDec.rtValue = rtValue;
        // Sign extend to register width
        nextDec.imm     = cpuPkg::dataT'(iForm.imm);
        nextDec.rd      = rForm.rd;
        nextDec.rl      = rForm.rl;
        nextDec.rt      = rForm.rt;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            decReg <= '0;
        end else begin
            decReg <= nextDec;
        end
    end

    assign decoded = decReg;

    // A stalled instruction never enters the pipeline
    noLoadWhileBusy: assert property (
        @(posedge clk) disable iff (!rst_n) busy |=> !decReg.valid
    ) else $error("decode register loaded while busy");

endmodule

/* logic/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
    input  logic            clk,
    input  logic            rst_n,
    input  cpuPkg::decodedT decoded,
    output cpuPkg::resultT  exItem
);

    cpuPkg::dataT   aluValue;
    cpuPkg::dataT   immValue;
    cpuPkg::wideT   product;
    logic           isEqual;
    logic           isLess;
    cpuPkg::resultT nextItem;

    // ----------------------------------------------------------------------
    // Datapath
    // ----------------------------------------------------------------------
    always_comb begin
        case (decoded.func)
            cpuPkg::FnAnd: aluValue = decoded.rsValue & decoded.rtValue;
            cpuPkg::FnOr:  aluValue = decoded.rsValue | decoded.rtValue;
            cpuPkg::FnXor: aluValue = decoded.rsValue ^ decoded.rtValue;
            cpuPkg::FnAdd: aluValue = decoded.rsValue + decoded.rtValue;
            cpuPkg::FnSub: aluValue = decoded.rsValue - decoded.rtValue;
            // Undefined codes write zero
            default:       aluValue = '0;
        endcase
    end

    // Immediate ops wrap at register width
    assign immValue = (decoded.opcode == cpuPkg::OpSubi) ?
                      decoded.rsValue - decoded.imm :
                      decoded.rsValue + decoded.imm;

    assign product = cpuPkg::wideT'(decoded.rsValue) * cpuPkg::wideT'(decoded.rtValue);

    // Signed compare, both operands are dataT
    assign isEqual = (decoded.rsValue == decoded.rtValue);
    assign isLess  = (decoded.rsValue < decoded.rtValue);

    always_comb begin
        nextItem.valid  = decoded.valid;
        nextItem.opcode = decoded.opcode;
        nextItem.rd     = decoded.rd;
        nextItem.rl     = decoded.rl;
        nextItem.rt     = decoded.rt;
        case (decoded.opcode)
            cpuPkg::OpRType: nextItem.result = cpuPkg::wideT'(aluValue);
            cpuPkg::OpMult:  nextItem.result = product;
            cpuPkg::OpBeq:   nextItem.result = cpuPkg::wideT'(isEqual);
            cpuPkg::OpSlt:   nextItem.result = cpuPkg::wideT'(isLess);
            cpuPkg::OpAddi, cpuPkg::OpSubi: begin
                nextItem.result = cpuPkg::wideT'(immValue);
            end
            default:         nextItem.result = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // Execute register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exItem <= '0;
        end else begin
            exItem <= nextItem;
        end
    end

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic            clk,
    input  logic            rst_n,
    input  cpuPkg::resultT  exItem,
    input  cpuPkg::regAddrT rsIndex,
    input  cpuPkg::regAddrT rtIndex,
    output cpuPkg::dataT    rsValue,
    output cpuPkg::dataT    rtValue,
    output logic            outValid,
    output cpuPkg::regViewT regView
);

    cpuPkg::regViewT regs;
    cpuPkg::dataT    lowHalf;
    cpuPkg::dataT    highHalf;
    logic            flag;

    assign lowHalf  = exItem.result[cpuPkg::DataWidth-1:0];
    assign highHalf = exItem.result[2*cpuPkg::DataWidth-1:cpuPkg::DataWidth];
    // BEQ and SLT outcome
    assign flag     = exItem.result[0];

    // ----------------------------------------------------------------------
    // Write-back
    // ----------------------------------------------------------------------
    // The rl write comes last so it wins on a shared index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs     <= '0;
            outValid <= 1'b0;
        end else begin
            outValid <= exItem.valid;
            if (exItem.valid) begin
                case (exItem.opcode)
                    cpuPkg::OpRType: regs[exItem.rd] <= lowHalf;
                    cpuPkg::OpMult: begin
                        regs[exItem.rd] <= highHalf;
                        regs[exItem.rl] <= lowHalf;
                    end
                    cpuPkg::OpBeq, cpuPkg::OpSlt: begin
                        regs[exItem.rd] <= cpuPkg::dataT'(flag);
                        regs[exItem.rl] <= cpuPkg::dataT'(!flag);
                    end
                    cpuPkg::OpAddi, cpuPkg::OpSubi: regs[exItem.rt] <= lowHalf;
                    // Store and load retire without a write
                    default: ;
                endcase
            end
        end
    end

    // ----------------------------------------------------------------------
    // Read ports and view
    // ----------------------------------------------------------------------
    assign rsValue = regs[rsIndex];
    assign rtValue = regs[rtIndex];
    assign regView = regs;

    // Back-to-back retire strobes need back-to-back execute items
    strobePerItem: assert property (
        @(posedge clk) disable iff (!rst_n)
        outValid && $past(outValid) |-> $past(exItem.valid) && $past(exItem.valid, 2)
    ) else $error("retire strobe held without execute items");

endmodule

/* logic/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            inValid,
    input  cpuPkg::instrT   instruction,
    output logic            busy,
    output logic            outValid,
    output cpuPkg::regViewT regView
);

    cpuPkg::decodedT decoded;
    cpuPkg::resultT  exItem;
    cpuPkg::regAddrT rsIndex;
    cpuPkg::regAddrT rtIndex;
    cpuPkg::dataT    rsValue;
    cpuPkg::dataT    rtValue;

    // Fetch, hazard check and decode register
    fetchStage u_fetchStage (
        .clk         (clk),
        .rst_n       (rst_n),
        .inValid     (inValid),
        .instruction (instruction),
        .exItem      (exItem),
        .rsValue     (rsValue),
        .rtValue     (rtValue),
        .busy        (busy),
        .rsIndex     (rsIndex),
        .rtIndex     (rtIndex),
        .decoded     (decoded)
    );

    executeStage u_executeStage (
        .clk     (clk),
        .rst_n   (rst_n),
        .decoded (decoded),
        .exItem  (exItem)
    );

    // Write-back and architectural state
    regFile u_regFile (
        .clk      (clk),
        .rst_n    (rst_n),
        .exItem   (exItem),
        .rsIndex  (rsIndex),
        .rtIndex  (rtIndex),
        .rsValue  (rsValue),
        .rtValue  (rtValue),
        .outValid (outValid),
        .regView  (regView)
    );

endmodule

/* testbench/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb;

    localparam int PatternCount   = 27;
    localparam int WatchdogCycles = PatternCount * 6 + 20;

    logic            clk;
    logic            rst_n;
    logic            inValid;
    cpuPkg::instrT   instruction;
    logic            busy;
    logic            outValid;
    cpuPkg::regViewT regView;

    // Three words per pattern: instruction, issue mode, expected view
    logic [255:0] patterns [0:3*PatternCount-1];
    int           acceptQ[$];
    int           cycle;
    int           retired;
    int           errors;

    cpuTop u_cpuTop (
        .clk         (clk),
        .rst_n       (rst_n),
        .inValid     (inValid),
        .instruction (instruction),
        .busy        (busy),
        .outValid    (outValid),
        .regView     (regView)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic checkValue(input logic [255:0] actual, input logic [255:0] expected,
                              input string msg);
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
        end
    endtask

    // ----------------------------------------------------------------------
    // Retire monitor on the falling edge
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && !inValid) begin
            checkValue(256'(busy), '0, "busy high while inValid low");
        end
        if (rst_n && outValid) begin
            if (retired >= PatternCount || acceptQ.size() == 0) begin
                errors++;
                $display("Retire strobe at %0t ns with no instruction left to retire", $time);
            end else begin
                checkValue(regView, patterns[3*retired+2],
                           $sformatf("register view after pattern %0d", retired));
                // Two edges from acceptance to the strobe
                checkValue(256'(cycle), 256'(acceptQ.pop_front() + 2), "retire latency");
            end
            retired++;
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    initial begin
        int   gap;
        int   mode;
        logic sawBusy;
        void'($urandom(32'hf87e4a86));
        $readmemh("testbench/cpuPatterns.txt", patterns);
        errors      = 0;
        retired     = 0;
        rst_n       = 1'b0;
        inValid     = 1'b0;
        instruction = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        checkValue(256'(busy), '0, "busy after reset");
        checkValue(256'(outValid), '0, "outValid after reset");
        checkValue(regView, '0, "register view after reset");
        @(posedge clk);
        for (int i = 0; i < PatternCount; i++) begin
            // Mode 0 allows idle gaps, 1 and 2 issue back to back, 2 must stall
            mode = int'(patterns[3*i+1][1:0]);
            gap  = (mode == 0) ? int'($urandom_range(2, 0)) : 0;
            if (gap > 0) begin
                inValid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            inValid     <= 1'b1;
            instruction <= patterns[3*i][cpuPkg::InstrWidth-1:0];
            sawBusy = 1'b0;
            @(negedge clk);
            while (busy) begin
                sawBusy = 1'b1;
                @(negedge clk);
            end
            // Taken on the coming rising edge
            acceptQ.push_back(cycle + 1);
            if (mode == 1) begin
                checkValue(256'(sawBusy), 256'(1'b0),
                           $sformatf("stall on independent pattern %0d", i));
            end else if (mode == 2) begin
                checkValue(256'(sawBusy), 256'(1'b1),
                           $sformatf("busy seen by dependent pattern %0d", i));
            end
            @(posedge clk);
        end
        inValid <= 1'b0;
        wait (retired >= PatternCount);
        repeat (4) @(posedge clk);
        checkValue(256'(retired), 256'(PatternCount), "number of retire strobes");
        $display("Retired %0d of %0d instructions with %0d errors", retired, PatternCount,
                 errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Timeout: run stopped after %0d cycles with %0d of %0d instructions retired",
                 WatchdogCycles, retired, PatternCount);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* testbench/cpuPatterns.txt */
// Columns: instruction (19 bits), issue mode (0 gap, 1 back to back, 2 must stall),
// expected register view after retire, r15 down to r0 with four hex digits each
30105 1 0000000000000000000000000000000000000000000000000000000000050000
302FD 1 00000000000000000000000000000000000000000000000000000FFFD00050000
403F9 1 00000000000000000000000000000000000000000000000000007FFFD00050000
40464 1 00000000000000000000000000000000000000000000FF9C0007FFFD00050000
3057F 1 000000000000000000000000000000000000000007FFF9C0007FFFD00050000
30680 1 00000000000000000000000000000000000FF80007FFF9C0007FFFD00050000
01470 0 000000000000000000000000000000000004FF80007FFF9C0007FFFD00050000
02381 0 000000000000000000000000000FFFF0004FF80007FFF9C0007FFFD00050000
04592 0 000000000000000000000000FFE3FFFF0004FF80007FFF9C0007FFFD00050000
026A3 0 00000000000000000000FF7DFFE3FFFF0004FF80007FFF9C0007FFFD00050000
014B4 0 00000000000000000069FF7DFFE3FFFF0004FF80007FFF9C0007FFFD00050000
01275 0 00000000000000000069FF7DFFE3FFFF0000FF80007FFF9C0007FFFD00050000
145CD 0 00000000CE64FFFF0069FF7DFFE3FFFF0000FF80007FFF9C0007FFFD00050000
145EE 0 0000CE64CE64FFFF0069FF7DFFE3FFFF0000FF80007FFF9C0007FFFD00050000
213FC 0 0000CE64CE6400010069FF7DFFE3FFFF0000FF80007FFF9C0007FFFD00050000
266F7 0 0001CE64CE6400010069FF7DFFE3FFFF0000FF80007FFF9C0007FFFD00050000
74189 0 0001CE64CE6400010069FF7D000000010000FF80007FFF9C0007FFFD00050000
756AB 0 0001CE64CE64000100010000000000010000FF80007FFF9C0007FFFD00050000
6ABCD 0 0001CE64CE64000100010000000000010000FF80007FFF9C0007FFFD00050000
51234 0 0001CE64CE64000100010000000000010000FF80007FFF9C0007FFFD00050000
31101 1 0001CE64CE64000100010000000000010000FF80007FFF9C0007FFFD00060000
31202 2 0001CE64CE64000100010000000000010000FF80007FFF9C0007000800060000
02134 2 0001CE64CE64000100010000000000010000FF80007FFF9C0002000800060000
30401 1 0001CE64CE64000100010000000000010000FF80007F00010002000800060000
03053 2 0001CE64CE64000100010000000000010000FF80000200010002000800060000
15469 2 0001CE64CE640001000100000002000100000000000200010002000800060000
798DE 2 0001000100000001000100000002000100000000000200010002000800060000

/* project.f */
logic/cpuPkg.sv
logic/fetchStage.sv
logic/executeStage.sv
logic/regFile.sv
logic/cpuTop.sv
testbench/cpuTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
